// ==== hdl/id_decoder.sv ====
/*
  Combinational RV32I decoder for OP, OP-IMM, LUI, AUIPC, LOAD, STORE,
  BRANCH and JAL. JALR, FENCE and SYSTEM words are flagged illegal.
*/
`timescale 1ns/1ps
`include "id_stage_cfg.svh"

module id_decoder import id_stage_pkg::*; (
  input  logic [31:0]                instr_rdata_i,
  output logic                       illegal_insn_o,
  output alu_op_e                    alu_operator_o,
  output op_a_sel_e                  op_a_sel_o,
  output op_b_sel_e                  op_b_sel_o,
  output imm_b_sel_e                 imm_b_sel_o,
  output logic [`ID_XLEN-1:0]        imm_i_o,
  output logic [`ID_XLEN-1:0]        imm_s_o,
  output logic [`ID_XLEN-1:0]        imm_b_o,
  output logic [`ID_XLEN-1:0]        imm_u_o,
  output logic [`ID_XLEN-1:0]        imm_j_o,
  output logic [`ID_REG_ADDR_W-1:0]  raddr_a_o,
  output logic [`ID_REG_ADDR_W-1:0]  raddr_b_o,
  output logic [`ID_REG_ADDR_W-1:0]  waddr_o,
  output logic                       regfile_we_o,
  output rf_wd_sel_e                 rf_wdata_sel_o,
  output logic                       data_req_o,
  output logic                       data_we_o,
  output data_type_e                 data_type_o,
  output logic                       data_sign_ext_o,
  output logic                       branch_in_dec_o,
  output logic                       jump_in_dec_o
);

  logic [6:0] funct7;
  logic [2:0] funct3;
  logic       illegal;

  assign funct7 = instr_rdata_i[31:25];
  assign funct3 = instr_rdata_i[14:12];

  assign raddr_a_o = instr_rdata_i[19:15];
  assign raddr_b_o = instr_rdata_i[24:20];
  assign waddr_o   = instr_rdata_i[11:7];

  //////////////////////////////////////////////////
  // Immediates
  //////////////////////////////////////////////////

  assign imm_i_o = {{20{instr_rdata_i[31]}}, instr_rdata_i[31:20]};
  assign imm_s_o = {{20{instr_rdata_i[31]}}, instr_rdata_i[31:25], instr_rdata_i[11:7]};
  assign imm_b_o = {{19{instr_rdata_i[31]}}, instr_rdata_i[31], instr_rdata_i[7],
                    instr_rdata_i[30:25], instr_rdata_i[11:8], 1'b0};
  assign imm_u_o = {instr_rdata_i[31:12], 12'b0};
  assign imm_j_o = {{12{instr_rdata_i[31]}}, instr_rdata_i[19:12], instr_rdata_i[20],
                    instr_rdata_i[30:21], 1'b0};

  //////////////////////////////////////////////////
  // Opcode and funct decode
  //////////////////////////////////////////////////

  always_comb begin
    illegal         = 1'b0;
    alu_operator_o  = ADD;
    op_a_sel_o      = OP_A_REG_A;
    op_b_sel_o      = OP_B_REG_B;
    imm_b_sel_o     = IMM_B_I;
    regfile_we_o    = 1'b0;
    rf_wdata_sel_o  = RF_WD_EX;
    data_req_o      = 1'b0;
    data_we_o       = 1'b0;
    data_type_o     = DT_WORD;
    data_sign_ext_o = 1'b0;
    branch_in_dec_o = 1'b0;
    jump_in_dec_o   = 1'b0;

    case (instr_rdata_i[6:0])
      LUI: begin
        op_a_sel_o   = OP_A_IMM;
        op_b_sel_o   = OP_B_IMM;
        imm_b_sel_o  = IMM_B_U;
        regfile_we_o = 1'b1;
      end
      AUIPC: begin
        op_a_sel_o   = OP_A_CURRPC;
        op_b_sel_o   = OP_B_IMM;
        imm_b_sel_o  = IMM_B_U;
        regfile_we_o = 1'b1;
      end
      JAL: begin
        // Link address pc + 4 comes back from EX
        jump_in_dec_o = 1'b1;
        op_a_sel_o    = OP_A_CURRPC;
        op_b_sel_o    = OP_B_IMM;
        imm_b_sel_o   = IMM_B_INCR_PC;
        regfile_we_o  = 1'b1;
      end
      BRANCH: begin
        branch_in_dec_o = 1'b1;
        imm_b_sel_o     = IMM_B_B;
        case (funct3)
          3'b000:  alu_operator_o = EQ;
          3'b001:  alu_operator_o = NE;
          3'b100:  alu_operator_o = LT;
          3'b101:  alu_operator_o = GE;
          3'b110:  alu_operator_o = LTU;
          3'b111:  alu_operator_o = GEU;
          default: illegal = 1'b1;
        endcase
      end
      LOAD: begin
        data_req_o     = 1'b1;
        op_b_sel_o     = OP_B_IMM;
        regfile_we_o   = 1'b1;
        rf_wdata_sel_o = RF_WD_LSU;
        // funct3[2] selects zero extension
        data_sign_ext_o = ~funct3[2];
        case (funct3)
          3'b000, 3'b100: data_type_o = DT_BYTE;
          3'b001, 3'b101: data_type_o = DT_HALF;
          3'b010:         data_type_o = DT_WORD;
          default:        illegal = 1'b1;
        endcase
      end
      STORE: begin
        data_req_o  = 1'b1;
        data_we_o   = 1'b1;
        op_b_sel_o  = OP_B_IMM;
        imm_b_sel_o = IMM_B_S;
        case (funct3)
          3'b000:  data_type_o = DT_BYTE;
          3'b001:  data_type_o = DT_HALF;
          3'b010:  data_type_o = DT_WORD;
          default: illegal = 1'b1;
        endcase
      end
      OP_IMM: begin
        op_b_sel_o   = OP_B_IMM;
        regfile_we_o = 1'b1;
        case (funct3)
          3'b000: alu_operator_o = ADD;
          3'b010: alu_operator_o = SLT;
          3'b011: alu_operator_o = SLTU;
          3'b100: alu_operator_o = XOR;
          3'b110: alu_operator_o = OR;
          3'b111: alu_operator_o = AND;
          3'b001: begin
            alu_operator_o = SLL;
            illegal        = (funct7 != 7'b0000000);
          end
          default: begin
            if (funct7 == 7'b0000000) begin
              alu_operator_o = SRL;
            end else if (funct7 == 7'b0100000) begin
              alu_operator_o = SRA;
            end else begin
              illegal = 1'b1;
            end
          end
        endcase
      end
      OP: begin
        regfile_we_o = 1'b1;
        case ({funct7, funct3})
          {7'b0000000, 3'b000}: alu_operator_o = ADD;
          {7'b0100000, 3'b000}: alu_operator_o = SUB;
          {7'b0000000, 3'b001}: alu_operator_o = SLL;
          {7'b0000000, 3'b010}: alu_operator_o = SLT;
          {7'b0000000, 3'b011}: alu_operator_o = SLTU;
          {7'b0000000, 3'b100}: alu_operator_o = XOR;
          {7'b0000000, 3'b101}: alu_operator_o = SRL;
          {7'b0100000, 3'b101}: alu_operator_o = SRA;
          {7'b0000000, 3'b110}: alu_operator_o = OR;
          {7'b0000000, 3'b111}: alu_operator_o = AND;
          default:              illegal = 1'b1;
        endcase
      end
      default: illegal = 1'b1;
    endcase

    // Illegal words must not write, request or redirect
    if (illegal) begin
      regfile_we_o    = 1'b0;
      data_req_o      = 1'b0;
      branch_in_dec_o = 1'b0;
      jump_in_dec_o   = 1'b0;
    end
  end

  assign illegal_insn_o = illegal;

endmodule

// ==== hdl/id_operand_mux.sv ====
/*
  ALU operand selection. A misaligned load or store overrides the decoded
  selection for its second access: operand A = last address, B = 4.
*/
`timescale 1ns/1ps
`include "id_stage_cfg.svh"

module id_operand_mux import id_stage_pkg::*; (
  input  op_a_sel_e                op_a_sel_i,
  input  op_b_sel_e                op_b_sel_i,
  input  imm_b_sel_e               imm_b_sel_i,
  input  logic [`ID_XLEN-1:0]      rdata_a_i,
  input  logic [`ID_XLEN-1:0]      rdata_b_i,
  input  logic [`ID_XLEN-1:0]      pc_id_i,
  input  logic [`ID_XLEN-1:0]      imm_i_i,
  input  logic [`ID_XLEN-1:0]      imm_s_i,
  input  logic [`ID_XLEN-1:0]      imm_b_i,
  input  logic [`ID_XLEN-1:0]      imm_u_i,
  input  logic [`ID_XLEN-1:0]      imm_j_i,
  input  logic                     lsu_addr_incr_req_i,
  input  logic [`ID_XLEN-1:0]      lsu_addr_last_i,
  output logic [`ID_XLEN-1:0]      alu_operand_a_o,
  output logic [`ID_XLEN-1:0]      alu_operand_b_o
);

  op_a_sel_e           op_a_sel;
  op_b_sel_e           op_b_sel;
  imm_b_sel_e          imm_b_sel;
  logic [`ID_XLEN-1:0] imm_b;

  // Second half of a misaligned access
  assign op_a_sel  = lsu_addr_incr_req_i ? OP_A_FWD        : op_a_sel_i;
  assign op_b_sel  = lsu_addr_incr_req_i ? OP_B_IMM        : op_b_sel_i;
  assign imm_b_sel = lsu_addr_incr_req_i ? IMM_B_INCR_ADDR : imm_b_sel_i;

  always_comb begin
    case (op_a_sel)
      OP_A_REG_A:  alu_operand_a_o = rdata_a_i;
      OP_A_FWD:    alu_operand_a_o = lsu_addr_last_i;
      OP_A_CURRPC: alu_operand_a_o = pc_id_i;
      default:     alu_operand_a_o = '0;
    endcase
  end

  always_comb begin
    case (imm_b_sel)
      IMM_B_I: imm_b = imm_i_i;
      IMM_B_S: imm_b = imm_s_i;
      IMM_B_B: imm_b = imm_b_i;
      IMM_B_U: imm_b = imm_u_i;
      IMM_B_J: imm_b = imm_j_i;
      default: imm_b = `ID_XLEN'd4;
    endcase
  end

  assign alu_operand_b_o = (op_b_sel == OP_B_IMM) ? imm_b : rdata_b_i;

  // Decoder select merged with the LSU override
  a_imm_b_sel_legal: assert final (!$isunknown(imm_b_sel) && imm_b_sel inside {
      IMM_B_I, IMM_B_S, IMM_B_B, IMM_B_U, IMM_B_J, IMM_B_INCR_PC, IMM_B_INCR_ADDR})
    else $error("illegal operand B immediate select");

endmodule

// ==== hdl/id_register_file.sv ====
/*
  Flip-flop register file, two read ports and one write port.
  Reads are combinational, so a write is visible the cycle after it.
*/
`timescale 1ns/1ps
`include "id_stage_cfg.svh"

module id_register_file import id_stage_pkg::*; (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic [`ID_REG_ADDR_W-1:0]  raddr_a_i,
  input  logic [`ID_REG_ADDR_W-1:0]  raddr_b_i,
  input  logic [`ID_REG_ADDR_W-1:0]  waddr_i,
  input  logic [`ID_XLEN-1:0]        wdata_i,
  input  logic                       we_i,
  output logic [`ID_XLEN-1:0]        rdata_a_o,
  output logic [`ID_XLEN-1:0]        rdata_b_o
);

  // Storage for x1 and up only
  logic [`ID_XLEN-1:0] regs_q [1:`ID_NUM_REGS-1];

  for (genvar i = 1; i < `ID_NUM_REGS; i++) begin : g_reg
    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        regs_q[i] <= '0;
      end else if (we_i && (waddr_i == i)) begin
        regs_q[i] <= wdata_i;
      end
    end
  end

  assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs_q[raddr_a_i];
  assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs_q[raddr_b_i];

  // Write enable comes from the sequencer FSM
  a_we_known: assert property (@(posedge clk_i) disable iff (!rst_ni) !$isunknown(we_i))
    else $error("register file write enable is unknown");

endmodule

// ==== hdl/id_stage.sv ====
/*
  Reduced RV32I instruction decode stage. No CSR, exceptions, interrupts,
  debug or compressed support. instr_rdata_i and pc_id_i must stay stable
  until id_in_ready_o accepts the instruction.
*/
`timescale 1ns/1ps
`include "id_stage_cfg.svh"

module id_stage import id_stage_pkg::*; (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 instr_valid_i,
  input  logic                 instr_new_i,
  input  logic [31:0]          instr_rdata_i,
  input  logic [`ID_XLEN-1:0]  pc_id_i,
  input  logic                 branch_decision_i,
  input  logic                 ex_valid_i,
  input  logic                 lsu_valid_i,
  input  logic                 lsu_addr_incr_req_i,
  input  logic [`ID_XLEN-1:0]  lsu_addr_last_i,
  input  logic [`ID_XLEN-1:0]  regfile_wdata_ex_i,
  input  logic [`ID_XLEN-1:0]  regfile_wdata_lsu_i,
  output logic                 id_in_ready_o,
  output logic                 pc_set_o,
  output logic                 illegal_insn_o,
  output logic                 instr_ret_o,
  output alu_op_e              alu_operator_o,
  output logic [`ID_XLEN-1:0]  alu_operand_a_o,
  output logic [`ID_XLEN-1:0]  alu_operand_b_o,
  output logic                 data_req_o,
  output logic                 data_we_o,
  output data_type_e           data_type_o,
  output logic                 data_sign_ext_o,
  output logic [`ID_XLEN-1:0]  data_wdata_o
);

  logic                      illegal_insn_dec;
  op_a_sel_e                 op_a_sel;
  op_b_sel_e                 op_b_sel;
  imm_b_sel_e                imm_b_sel;
  logic [`ID_XLEN-1:0]       imm_i, imm_s, imm_b, imm_u, imm_j;
  logic [`ID_REG_ADDR_W-1:0] raddr_a, raddr_b, waddr;
  logic [`ID_XLEN-1:0]       rdata_a, rdata_b;
  logic [`ID_XLEN-1:0]       rf_wdata;
  rf_wd_sel_e                rf_wdata_sel;
  logic                      regfile_we_dec;
  logic                      rf_we;
  logic                      data_req_dec;
  logic                      branch_in_dec;
  logic                      jump_in_dec;

  id_decoder u_decoder (
    .instr_rdata_i   (instr_rdata_i),
    .illegal_insn_o  (illegal_insn_dec),
    .alu_operator_o  (alu_operator_o),
    .op_a_sel_o      (op_a_sel),
    .op_b_sel_o      (op_b_sel),
    .imm_b_sel_o     (imm_b_sel),
    .imm_i_o         (imm_i),
    .imm_s_o         (imm_s),
    .imm_b_o         (imm_b),
    .imm_u_o         (imm_u),
    .imm_j_o         (imm_j),
    .raddr_a_o       (raddr_a),
    .raddr_b_o       (raddr_b),
    .waddr_o         (waddr),
    .regfile_we_o    (regfile_we_dec),
    .rf_wdata_sel_o  (rf_wdata_sel),
    .data_req_o      (data_req_dec),
    .data_we_o       (data_we_o),
    .data_type_o     (data_type_o),
    .data_sign_ext_o (data_sign_ext_o),
    .branch_in_dec_o (branch_in_dec),
    .jump_in_dec_o   (jump_in_dec)
  );

  // Loads write the LSU data, everything else the EX result
  assign rf_wdata = (rf_wdata_sel == RF_WD_LSU) ? regfile_wdata_lsu_i : regfile_wdata_ex_i;

  id_register_file u_register_file (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .raddr_a_i (raddr_a),
    .raddr_b_i (raddr_b),
    .waddr_i   (waddr),
    .wdata_i   (rf_wdata),
    .we_i      (rf_we),
    .rdata_a_o (rdata_a),
    .rdata_b_o (rdata_b)
  );

  id_operand_mux u_operand_mux (
    .op_a_sel_i          (op_a_sel),
    .op_b_sel_i          (op_b_sel),
    .imm_b_sel_i         (imm_b_sel),
    .rdata_a_i           (rdata_a),
    .rdata_b_i           (rdata_b),
    .pc_id_i             (pc_id_i),
    .imm_i_i             (imm_i),
    .imm_s_i             (imm_s),
    .imm_b_i             (imm_b),
    .imm_u_i             (imm_u),
    .imm_j_i             (imm_j),
    .lsu_addr_incr_req_i (lsu_addr_incr_req_i),
    .lsu_addr_last_i     (lsu_addr_last_i),
    .alu_operand_a_o     (alu_operand_a_o),
    .alu_operand_b_o     (alu_operand_b_o)
  );

  id_wb_sequencer u_wb_sequencer (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .instr_new_i       (instr_new_i),
    .data_req_dec_i    (data_req_dec),
    .branch_in_dec_i   (branch_in_dec),
    .jump_in_dec_i     (jump_in_dec),
    .regfile_we_dec_i  (regfile_we_dec),
    .branch_decision_i (branch_decision_i),
    .ex_valid_i        (ex_valid_i),
    .lsu_valid_i       (lsu_valid_i),
    .rf_we_o           (rf_we),
    .data_req_o        (data_req_o),
    .id_in_ready_o     (id_in_ready_o),
    .pc_set_o          (pc_set_o),
    .instr_ret_o       (instr_ret_o)
  );

  assign illegal_insn_o = instr_valid_i & illegal_insn_dec;
  // Store data is rs2
  assign data_wdata_o   = rdata_b;

endmodule

// ==== hdl/id_stage_cfg.svh ====
/*
  Width and size constants for the decode stage.
  The stage is written for RV32I only, so ID_XLEN must stay 32.
*/
`ifndef ID_STAGE_CFG_SVH
`define ID_STAGE_CFG_SVH

// Data path and operand width
`define ID_XLEN 32

// Register file geometry
`define ID_REG_ADDR_W 5
`define ID_NUM_REGS 32

`endif

// ==== hdl/id_stage_pkg.sv ====
/*
  Shared enumerations for the reduced RV32I decode stage.
  Only the opcodes listed in opcode_e are decoded; all others are illegal.
*/
package id_stage_pkg;

  // Major opcodes, instruction bits 6:0
  typedef enum logic [6:0] {
    LOAD   = 7'h03,
    OP_IMM = 7'h13,
    AUIPC  = 7'h17,
    STORE  = 7'h23,
    OP     = 7'h33,
    LUI    = 7'h37,
    BRANCH = 7'h63,
    JAL    = 7'h6f
  } opcode_e;

  // ALU operations, comparisons are used by branches
  typedef enum logic [4:0] {
    ADD, SUB,
    XOR, OR, AND,
    SLL, SRL, SRA,
    SLT, SLTU,
    EQ, NE, LT, GE, LTU, GEU
  } alu_op_e;

  typedef enum logic [1:0] {
    OP_A_REG_A,
    OP_A_FWD,
    OP_A_CURRPC,
    OP_A_IMM
  } op_a_sel_e;

  typedef enum logic {
    OP_B_REG_B,
    OP_B_IMM
  } op_b_sel_e;

  typedef enum logic [2:0] {
    IMM_B_I,
    IMM_B_S,
    IMM_B_B,
    IMM_B_U,
    IMM_B_J,
    IMM_B_INCR_PC,
    IMM_B_INCR_ADDR
  } imm_b_sel_e;

  typedef enum logic {
    RF_WD_EX,
    RF_WD_LSU
  } rf_wd_sel_e;

  // Memory access size
  typedef enum logic [1:0] {
    DT_WORD = 2'b00,
    DT_HALF = 2'b01,
    DT_BYTE = 2'b10
  } data_type_e;

  // ID-EX/WB sequencer states
  typedef enum logic {
    IDLE,
    WAIT_MULTICYCLE
  } id_fsm_e;

endpackage

// ==== hdl/id_wb_sequencer.sv ====
/*
  ID-EX/WB sequencer. Loads, stores, taken branches and JAL stall the stage
  until lsu_valid_i (memory) or ex_valid_i (others). branch_decision_i must
  be valid while instr_new_i is high for a branch.
*/
`timescale 1ns/1ps

module id_wb_sequencer import id_stage_pkg::*; (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic instr_new_i,
  input  logic data_req_dec_i,
  input  logic branch_in_dec_i,
  input  logic jump_in_dec_i,
  input  logic regfile_we_dec_i,
  input  logic branch_decision_i,
  input  logic ex_valid_i,
  input  logic lsu_valid_i,
  output logic rf_we_o,
  output logic data_req_o,
  output logic id_in_ready_o,
  output logic pc_set_o,
  output logic instr_ret_o
);

  id_fsm_e state_q, state_d;
  logic    done_q, done_d;
  logic    branch_set_q, branch_set_d;
  logic    instr_multicycle;
  logic    instr_executing;
  logic    we_wb;
  logic    jump_set;
  logic    stall;

  assign instr_multicycle = data_req_dec_i | branch_in_dec_i | jump_in_dec_i;

  // New instruction, or a multicycle one still in flight
  assign instr_executing = instr_new_i | (instr_multicycle & ~done_q);

  // Done flag starts set so nothing is issued before the first instruction
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q      <= IDLE;
      done_q       <= 1'b1;
      branch_set_q <= 1'b0;
    end else begin
      state_q      <= state_d;
      done_q       <= done_d;
      branch_set_q <= branch_set_d;
    end
  end

  always_comb begin
    state_d      = state_q;
    done_d       = done_q;
    branch_set_d = 1'b0;
    we_wb        = 1'b0;
    jump_set     = 1'b0;
    stall        = 1'b0;
    instr_ret_o  = 1'b0;

    unique case (state_q)
      IDLE: begin
        if (instr_new_i) begin
          if (data_req_dec_i || jump_in_dec_i ||
              (branch_in_dec_i && branch_decision_i)) begin
            state_d      = WAIT_MULTICYCLE;
            done_d       = 1'b0;
            stall        = 1'b1;
            jump_set     = jump_in_dec_i;
            branch_set_d = branch_in_dec_i;
          end else begin
            // Single cycle, or a branch that is not taken
            done_d      = 1'b1;
            instr_ret_o = 1'b1;
          end
        end
      end
      WAIT_MULTICYCLE: begin
        if ((data_req_dec_i && lsu_valid_i) || (!data_req_dec_i && ex_valid_i)) begin
          state_d     = IDLE;
          done_d      = 1'b1;
          we_wb       = regfile_we_dec_i;
          instr_ret_o = 1'b1;
        end else begin
          stall = 1'b1;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  // Multicycle results are written only in the ending cycle
  assign rf_we_o       = instr_executing & (instr_multicycle ? we_wb : regfile_we_dec_i);
  assign data_req_o    = instr_executing & data_req_dec_i;
  assign id_in_ready_o = ~stall;
  assign pc_set_o      = jump_set | branch_set_q;

  a_class_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni)
      $onehot0({data_req_dec_i, branch_in_dec_i, jump_in_dec_i}))
    else $error("more than one multicycle class decoded");

  a_state_known: assert property (@(posedge clk_i) disable iff (!rst_ni)
      !$isunknown(state_q))
    else $error("sequencer state is unknown");

endmodule

// ==== id_stage_lite.f ====
+incdir+hdl
hdl/id_stage_pkg.sv
hdl/id_decoder.sv
hdl/id_register_file.sv
hdl/id_operand_mux.sv
hdl/id_wb_sequencer.sv
hdl/id_stage.sv
verif/id_stage_tb.sv

// ==== verif/id_stage_tb.sv ====
/*
  Random testbench for the decode stage. The testbench plays the fetch, EX
  and LSU sides itself, with 0 to 5 wait cycles per multicycle instruction.
  Register contents are tracked in a 32-entry model.
*/
`timescale 1ns/1ps
`include "id_stage_cfg.svh"

module id_stage_tb import id_stage_pkg::*; ();

  localparam int     CLK_PERIOD = 40;
  localparam int     RST_CYCLES = 3;
  localparam int     NUM_INSTR  = 400;
  localparam int     MAX_DELAY  = 5;
  // At most 8 cycles per instruction including the gap cycle
  localparam longint TIMEOUT_NS = longint'(NUM_INSTR) * 8 * CLK_PERIOD
                                  + (RST_CYCLES + 2) * CLK_PERIOD;

  logic                clk_i;
  logic                rst_ni;
  logic                instr_valid_i;
  logic                instr_new_i;
  logic [31:0]         instr_rdata_i;
  logic [`ID_XLEN-1:0] pc_id_i;
  logic                branch_decision_i;
  logic                ex_valid_i;
  logic                lsu_valid_i;
  logic                lsu_addr_incr_req_i;
  logic [`ID_XLEN-1:0] lsu_addr_last_i;
  logic [`ID_XLEN-1:0] regfile_wdata_ex_i;
  logic [`ID_XLEN-1:0] regfile_wdata_lsu_i;
  logic                id_in_ready_o;
  logic                pc_set_o;
  logic                illegal_insn_o;
  logic                instr_ret_o;
  alu_op_e             alu_operator_o;
  logic [`ID_XLEN-1:0] alu_operand_a_o;
  logic [`ID_XLEN-1:0] alu_operand_b_o;
  logic                data_req_o;
  logic                data_we_o;
  data_type_e          data_type_o;
  logic                data_sign_ext_o;
  logic [`ID_XLEN-1:0] data_wdata_o;

  // Reference register contents
  logic [`ID_XLEN-1:0] model_regs [`ID_NUM_REGS];

  id_stage dut (.*);

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  initial begin
    #(TIMEOUT_NS);
    $display("Timeout: the stage did not finish all instructions in time");
    stop_on_error();
  end

  //////////////////////////////////////////////////
  // Compare tasks
  //////////////////////////////////////////////////

  task automatic stop_on_error();
    $display("TEST FAIL");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_flag(input logic exp, input logic act, input string name);
    if (act !== exp) begin
      $display("MISMATCH at %0t: %s expected %b, got %b", $time, name, exp, act);
      stop_on_error();
    end
  endtask

  task automatic check_word(input logic [`ID_XLEN-1:0] exp, input logic [`ID_XLEN-1:0] act,
                            input string name);
    if (act !== exp) begin
      $display("MISMATCH at %0t: %s expected %h, got %h", $time, name, exp, act);
      stop_on_error();
    end
  endtask

  task automatic check_alu_op(input alu_op_e exp, input alu_op_e act, input string name);
    if (act !== exp) begin
      $display("MISMATCH at %0t: %s expected %s (%0d), got %s (%0d)", $time, name,
               exp.name(), exp, act.name(), act);
      stop_on_error();
    end
  endtask

  task automatic check_dtype(input data_type_e exp, input data_type_e act, input string name);
    if (act !== exp) begin
      $display("MISMATCH at %0t: %s expected %s (%0d), got %s (%0d)", $time, name,
               exp.name(), exp, act.name(), act);
      stop_on_error();
    end
  endtask

  //////////////////////////////////////////////////
  // Instruction generation and ISA rules
  //////////////////////////////////////////////////

  function automatic logic [31:0] gen_word();
    logic [31:0] w;
    int          kind;
    int          t;
    w    = $urandom;
    kind = $urandom_range(0, 9);
    t    = $urandom_range(0, 5);
    case (kind)
      0: begin
        w[6:0]   = OP;
        w[31:25] = ((w[14:12] == 3'b000 || w[14:12] == 3'b101) && w[31]) ? 7'h20 : 7'h00;
      end
      1: begin
        w[6:0] = OP_IMM;
        if (w[14:12] == 3'b001) w[31:25] = 7'h00;
        else if (w[14:12] == 3'b101) w[31:25] = w[30] ? 7'h20 : 7'h00;
      end
      2: w[6:0] = LUI;
      3: w[6:0] = AUIPC;
      4: begin
        w[6:0]    = LOAD;
        w[14:12]  = (t % 5 > 2) ? 3'(t % 5 + 1) : 3'(t % 5);
      end
      5: begin
        w[6:0]   = STORE;
        w[14:12] = 3'(t % 3);
      end
      6, 7: begin
        w[6:0]   = BRANCH;
        w[14:12] = (t > 1) ? 3'(t + 2) : 3'(t);
      end
      8: w[6:0] = JAL;
      default: begin
        // JALR, SYSTEM, reserved load width, M extension
        case (t % 4)
          0: w[6:0] = 7'h67;
          1: w[6:0] = 7'h73;
          2: begin
            w[6:0]   = LOAD;
            w[14:12] = w[13] ? 3'b011 : 3'b110;
          end
          default: begin
            w[6:0]   = OP;
            w[31:25] = 7'h01;
          end
        endcase
      end
    endcase
    return w;
  endfunction

  function automatic logic word_legal(input logic [31:0] w);
    logic [2:0] f3;
    logic [6:0] f7;
    f3 = w[14:12];
    f7 = w[31:25];
    case (w[6:0])
      LUI, AUIPC, JAL: return 1'b1;
      LOAD:   return !(f3 == 3'b011 || f3 == 3'b110 || f3 == 3'b111);
      STORE:  return f3 <= 3'b010;
      BRANCH: return f3[2:1] != 2'b01;
      OP_IMM: begin
        if (f3 == 3'b001) return f7 == 7'h00;
        if (f3 == 3'b101) return f7 == 7'h00 || f7 == 7'h20;
        return 1'b1;
      end
      OP:     return f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'b000 || f3 == 3'b101));
      default: return 1'b0;
    endcase
  endfunction

  function automatic alu_op_e exp_alu_op(input logic [31:0] w);
    logic [2:0] f3;
    f3 = w[14:12];
    if (w[6:0] == BRANCH) begin
      case (f3)
        3'b000:  return EQ;
        3'b001:  return NE;
        3'b100:  return LT;
        3'b101:  return GE;
        3'b110:  return LTU;
        default: return GEU;
      endcase
    end
    if (w[6:0] != OP && w[6:0] != OP_IMM) return ADD;
    case (f3)
      3'b000:  return (w[6:0] == OP && w[30]) ? SUB : ADD;
      3'b001:  return SLL;
      3'b010:  return SLT;
      3'b011:  return SLTU;
      3'b100:  return XOR;
      3'b101:  return w[30] ? SRA : SRL;
      3'b110:  return OR;
      default: return AND;
    endcase
  endfunction

  //////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////

  // EX and LSU side defaults for a new cycle
  task automatic refresh_responses();
    ex_valid_i          = 1'b0;
    lsu_valid_i         = 1'b0;
    lsu_addr_incr_req_i = 1'b0;
    lsu_addr_last_i     = $urandom;
    regfile_wdata_ex_i  = $urandom;
    regfile_wdata_lsu_i = $urandom;
  endtask

  task automatic idle_cycle();
    @(negedge clk_i);
    refresh_responses();
    instr_valid_i     = 1'b0;
    instr_new_i       = 1'b0;
    instr_rdata_i     = $urandom;
    branch_decision_i = 1'($urandom_range(0, 1));
    #1;
    check_flag(1'b0, illegal_insn_o, "illegal_insn_o");
    check_flag(1'b0, instr_ret_o, "instr_ret_o");
    check_flag(1'b1, id_in_ready_o, "id_in_ready_o");
    check_flag(1'b0, data_req_o, "data_req_o");
    check_flag(1'b0, pc_set_o, "pc_set_o");
  endtask

  task automatic execute_instr(input logic [31:0] w);
    logic [6:0]          opc;
    logic                legal, is_load, is_store, is_mem, is_branch, is_jal;
    logic                taken, multi, writes, last;
    logic [`ID_XLEN-1:0] pc, exp_a, exp_b, wdata;
    data_type_e          exp_dt;
    int                  delay;
    int                  k;
    opc       = w[6:0];
    legal     = word_legal(w);
    is_load   = legal && opc == LOAD;
    is_store  = legal && opc == STORE;
    is_mem    = is_load || is_store;
    is_branch = legal && opc == BRANCH;
    is_jal    = legal && opc == JAL;
    pc        = $urandom & 32'hffff_fffc;
    taken     = 1'($urandom_range(0, 1));
    multi     = is_mem || is_jal || (is_branch && taken);
    writes    = legal && !is_store && !is_branch;
    exp_dt    = (w[13:12] == 2'b00) ? DT_BYTE : (w[13:12] == 2'b01) ? DT_HALF : DT_WORD;
    case (opc)
      LUI:        exp_a = '0;
      AUIPC, JAL: exp_a = pc;
      default:    exp_a = model_regs[w[19:15]];
    endcase
    // Immediates as signed 12-bit values or an upper 20-bit field
    case (opc)
      OP, BRANCH:   exp_b = model_regs[w[24:20]];
      OP_IMM, LOAD: exp_b = 32'($signed(w[31:20]));
      STORE:        exp_b = 32'($signed({w[31:25], w[11:7]}));
      LUI, AUIPC:   exp_b = w[31:12] << 12;
      default:      exp_b = 32'd4;
    endcase

    @(negedge clk_i);
    refresh_responses();
    instr_valid_i     = 1'b1;
    instr_new_i       = 1'b1;
    instr_rdata_i     = w;
    pc_id_i           = pc;
    branch_decision_i = taken;
    #1;
    check_flag(!legal, illegal_insn_o, "illegal_insn_o");
    check_flag(is_mem, data_req_o, "data_req_o");
    check_flag(is_jal, pc_set_o, "pc_set_o");
    if (legal) begin
      check_flag(!multi, id_in_ready_o, "id_in_ready_o");
      check_flag(!multi, instr_ret_o, "instr_ret_o");
      check_alu_op(exp_alu_op(w), alu_operator_o, "alu_operator_o");
      check_word(exp_a, alu_operand_a_o, "alu_operand_a_o");
      check_word(exp_b, alu_operand_b_o, "alu_operand_b_o");
    end
    if (is_mem) begin
      check_flag(is_store, data_we_o, "data_we_o");
      check_dtype(exp_dt, data_type_o, "data_type_o");
      if (is_load) check_flag(!w[14], data_sign_ext_o, "data_sign_ext_o");
      if (is_store) check_word(model_regs[w[24:20]], data_wdata_o, "data_wdata_o");
    end
    wdata = regfile_wdata_ex_i;

    // Wait for the EX or LSU side with a random latency
    if (multi) begin
      delay = $urandom_range(0, MAX_DELAY);
      for (k = 1; k <= delay + 1; k++) begin
        @(negedge clk_i);
        refresh_responses();
        instr_new_i = 1'b0;
        last        = (k == delay + 1);
        if (last && is_mem) lsu_valid_i = 1'b1;
        else if (last) ex_valid_i = 1'b1;
        if (is_mem) lsu_addr_incr_req_i = 1'($urandom_range(0, 1));
        #1;
        check_flag(last, id_in_ready_o, "id_in_ready_o");
        check_flag(last, instr_ret_o, "instr_ret_o");
        check_flag(is_branch && k == 1, pc_set_o, "pc_set_o");
        check_flag(is_mem, data_req_o, "data_req_o");
        if (lsu_addr_incr_req_i) begin
          check_word(lsu_addr_last_i, alu_operand_a_o, "alu_operand_a_o");
          check_word(32'd4, alu_operand_b_o, "alu_operand_b_o");
        end else begin
          check_word(exp_a, alu_operand_a_o, "alu_operand_a_o");
          check_word(exp_b, alu_operand_b_o, "alu_operand_b_o");
        end
      end
      wdata = is_load ? regfile_wdata_lsu_i : regfile_wdata_ex_i;
    end

    // Write lands at the next rising edge
    if (writes && w[11:7] != 5'd0) model_regs[w[11:7]] = wdata;
  endtask

  initial begin
    int i;
    void'($urandom(38));
    clk_i               = 1'b0;
    rst_ni              = 1'b0;
    instr_valid_i       = 1'b0;
    instr_new_i         = 1'b0;
    instr_rdata_i       = '0;
    pc_id_i             = '0;
    branch_decision_i   = 1'b0;
    ex_valid_i          = 1'b0;
    lsu_valid_i         = 1'b0;
    lsu_addr_incr_req_i = 1'b0;
    lsu_addr_last_i     = '0;
    regfile_wdata_ex_i  = '0;
    regfile_wdata_lsu_i = '0;
    for (i = 0; i < `ID_NUM_REGS; i++) model_regs[i] = '0;

    repeat (RST_CYCLES) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    idle_cycle();

    for (i = 0; i < NUM_INSTR; i++) begin
      if ($urandom_range(0, 3) == 0) idle_cycle();
      execute_instr(gen_word());
    end

    $display("TEST PASS");
    $finish;
  end

endmodule
